// ==== source/usb_line_pkg.sv ====
package usb_line_pkg;

	// Raw DP/DM pair, DP in the upper bit
	typedef logic [1:0] line_pair_t;

	localparam line_pair_t PAIR_J   = 2'b10;
	localparam line_pair_t PAIR_K   = 2'b01;
	localparam line_pair_t PAIR_SE0 = 2'b00;
	localparam line_pair_t PAIR_SE1 = 2'b11;

	// Classified line state
	typedef enum logic [1:0] {
		LINE_J,
		LINE_K,
		LINE_SE0,
		LINE_SE1
	} line_state_t;

endpackage : usb_line_pkg

// ==== source/usb_packet_pkg.sv ====
package usb_packet_pkg;

	// Last eight received bits, newest bit in the MSB
	typedef logic [7:0] pattern_t;

	// One-hot packet ID
	typedef logic [2:0] pid_t;

	localparam pid_t PID_NONE  = 3'b000;
	localparam pid_t PID_ACK   = 3'b001;
	localparam pid_t PID_NAK   = 3'b010;
	localparam pid_t PID_DATA0 = 3'b100;

	// Bit patterns as they sit in the right-shifting register
	localparam pattern_t SYNC_PATTERN = 8'h2A;
	localparam pattern_t ACK_CODE     = 8'h1B;
	localparam pattern_t NAK_CODE     = 8'h63;
	localparam pattern_t DATA0_CODE   = 8'h14;

	typedef logic [15:0] crc_t;

	localparam crc_t CRC_POLY = 16'h8005;
	localparam crc_t CRC_INIT = 16'hFFFF;

	typedef enum logic [3:0] {
		IDLE,
		WAIT_SYNC,
		GET_PID,
		CHECK_PID,
		PAYLOAD,
		EOP_SE0A,
		EOP_SE0B,
		EOP_J,
		DONE
	} rx_state_t;

endpackage : usb_packet_pkg

// ==== source/line_decoder.sv ====
`timescale 1ns/1ps

module line_decoder import usb_line_pkg::*; (
	input  logic        clock,
	input  logic        reset_n,
	input  logic        dp,
	input  logic        dm,
	output line_state_t line_state,
	output logic        bit_val,
	output logic        bit_valid
);

	line_pair_t pair_q;

	// Pins come straight off the pads, register before use
	always_ff @(posedge clock, negedge reset_n) begin
		if (!reset_n) begin
			pair_q <= PAIR_J;
		end else begin
			pair_q <= {dp, dm};
		end
	end

	always_comb begin
		unique case (pair_q)
			PAIR_J: begin
				line_state = LINE_J;
			end
			PAIR_K: begin
				line_state = LINE_K;
			end
			PAIR_SE0: begin
				line_state = LINE_SE0;
			end
			PAIR_SE1: begin
				line_state = LINE_SE1;
			end
		endcase
	end

	// Only differential states carry data
	assign bit_valid = (line_state == LINE_J) || (line_state == LINE_K);
	assign bit_val   = (line_state == LINE_J);

endmodule : line_decoder

// ==== source/pattern_matcher.sv ====
`timescale 1ns/1ps

module pattern_matcher import usb_packet_pkg::*; (
	input  logic clock,
	input  logic reset_n,
	input  logic bit_val,
	input  logic bit_valid,
	input  logic clear_pattern,
	output logic sync_seen,
	output pid_t pid
);

	pattern_t pattern;

	// New bit enters at the top, oldest falls out at bit 0
	always_ff @(posedge clock, negedge reset_n) begin
		if (!reset_n) begin
			pattern <= '0;
		end else if (clear_pattern) begin
			pattern <= '0;
		end else if (bit_valid) begin
			pattern <= {bit_val, pattern[7:1]};
		end
	end

	assign sync_seen = (pattern == SYNC_PATTERN);

	always_comb begin
		case (pattern)
			ACK_CODE: begin
				pid = PID_ACK;
			end
			NAK_CODE: begin
				pid = PID_NAK;
			end
			DATA0_CODE: begin
				pid = PID_DATA0;
			end
			default: begin
				pid = PID_NONE;
			end
		endcase
	end

endmodule : pattern_matcher

// ==== source/payload_collector.sv ====
`timescale 1ns/1ps

module payload_collector import usb_packet_pkg::*; #(
	parameter int PAYLOAD_BITS = 32
) (
	input  logic                    clock,
	input  logic                    reset_n,
	input  logic                    collect_start,
	input  logic                    bit_val,
	input  logic                    bit_valid,
	output logic                    field_done,
	output logic [PAYLOAD_BITS-1:0] payload,
	output logic                    crc_ok
);

	localparam int TOTAL_BITS = PAYLOAD_BITS + $bits(crc_t);
	localparam int COUNT_W = $clog2(TOTAL_BITS + 1);
	localparam logic [COUNT_W-1:0] PAYLOAD_COUNT = COUNT_W'(PAYLOAD_BITS);
	localparam logic [COUNT_W-1:0] LAST_COUNT = COUNT_W'(TOTAL_BITS - 1);

	logic [COUNT_W-1:0]      bit_count, count_base;
	logic [PAYLOAD_BITS-1:0] payload_base;
	logic                    active, take, in_payload, last_bit, feedback;
	crc_t                    crc, crc_base, crc_next, rx_crc, rx_crc_next;

	// First payload bit can arrive together with collect_start
	always_comb begin
		count_base   = collect_start ? '0 : bit_count;
		payload_base = collect_start ? '0 : payload;
		crc_base     = collect_start ? CRC_INIT : crc;
		take         = bit_valid && (collect_start || active);
		in_payload   = (count_base < PAYLOAD_COUNT);
		last_bit     = take && (count_base == LAST_COUNT);
		feedback     = crc_base[15] ^ bit_val;
		crc_next     = {crc_base[14:0], 1'b0} ^ (feedback ? CRC_POLY : '0);
		rx_crc_next  = {rx_crc[14:0], bit_val};
	end

	always_ff @(posedge clock, negedge reset_n) begin
		if (!reset_n) begin
			bit_count  <= '0;
			active     <= 1'b0;
			field_done <= 1'b0;
			crc_ok     <= 1'b0;
		end else begin
			field_done <= last_bit;
			if (take) begin
				bit_count <= count_base + 1'b1;
			end else if (collect_start) begin
				bit_count <= '0;
			end
			if (last_bit) begin
				active <= 1'b0;
				// Sender transmits the complemented remainder
				crc_ok <= (rx_crc_next == ~crc);
			end else if (collect_start) begin
				active <= 1'b1;
				crc_ok <= 1'b0;
			end
		end
	end

	// Payload feeds the running CRC, the last 16 bits are the received CRC
	always_ff @(posedge clock) begin
		if (take && in_payload) begin
			payload <= {payload_base[PAYLOAD_BITS-2:0], bit_val};
			crc     <= crc_next;
		end else if (take) begin
			rx_crc <= rx_crc_next;
		end else if (collect_start) begin
			payload <= '0;
			crc     <= CRC_INIT;
		end
	end

endmodule : payload_collector

// ==== source/packet_fsm.sv ====
`timescale 1ns/1ps

module packet_fsm import usb_line_pkg::*, usb_packet_pkg::*; (
	input  logic        clock,
	input  logic        reset_n,
	input  logic        host_sending,
	input  line_state_t line_state,
	input  logic        bit_valid,
	input  logic        sync_seen,
	input  pid_t        pid,
	input  logic        field_done,
	output logic        clear_pattern,
	output logic        collect_start,
	output logic        ack_rec,
	output logic        nak_rec,
	output logic        data0_rec,
	output logic        pid_error,
	output logic        line_error
);

	rx_state_t state, next_state;
	logic [2:0] pid_count;
	pid_t       held_pid;
	logic       in_packet;

	// DONE is left out so its result strobe stays alone
	assign in_packet = (state != IDLE) && (state != DONE);

	always_comb begin
		next_state    = state;
		clear_pattern = 1'b0;
		collect_start = 1'b0;
		pid_error     = 1'b0;
		line_error    = 1'b0;
		if (in_packet && host_sending) begin
			// Host took the bus, drop the packet without a result
			next_state = IDLE;
		end else if (in_packet && line_state == LINE_SE1) begin
			line_error = 1'b1;
			next_state = IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (!host_sending) begin
						clear_pattern = 1'b1;
						next_state    = WAIT_SYNC;
					end
				end
				WAIT_SYNC: begin
					if (sync_seen) begin
						next_state = GET_PID;
					end
				end
				GET_PID: begin
					if (bit_valid && pid_count == 3'd7) begin
						next_state = CHECK_PID;
					end
				end
				CHECK_PID: begin
					if (pid == PID_ACK || pid == PID_NAK) begin
						next_state = EOP_SE0A;
					end else if (pid == PID_DATA0) begin
						collect_start = 1'b1;
						next_state    = PAYLOAD;
					end else begin
						pid_error  = 1'b1;
						next_state = IDLE;
					end
				end
				PAYLOAD: begin
					// Collector finishes in the cycle of the first EOP sample
					if (field_done) begin
						next_state = EOP_SE0A;
					end else if (line_state == LINE_SE0) begin
						line_error = 1'b1;
						next_state = IDLE;
					end
				end
				EOP_SE0A: begin
					// First SE0 went by, the second is on the line now
					if (line_state == LINE_SE0) begin
						next_state = EOP_SE0B;
					end else begin
						line_error = 1'b1;
						next_state = IDLE;
					end
				end
				EOP_SE0B: begin
					if (line_state == LINE_J) begin
						next_state = DONE;
					end else if (line_state == LINE_SE0) begin
						next_state = EOP_J;
					end else begin
						line_error = 1'b1;
						next_state = IDLE;
					end
				end
				EOP_J: begin
					// Stretched SE0, hold until the J arrives
					if (line_state == LINE_J) begin
						next_state = DONE;
					end else if (line_state == LINE_K) begin
						line_error = 1'b1;
						next_state = IDLE;
					end
				end
				default: begin
					next_state = IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock, negedge reset_n) begin
		if (!reset_n) begin
			state     <= IDLE;
			pid_count <= 3'd0;
			held_pid  <= PID_NONE;
		end else begin
			state <= next_state;
			// The bit on the line as SYNC completes is PID bit 0
			if (state == WAIT_SYNC) begin
				pid_count <= {2'b00, bit_valid};
			end else if (state == GET_PID && bit_valid) begin
				pid_count <= pid_count + 3'd1;
			end
			if (state == CHECK_PID) begin
				held_pid <= pid;
			end
		end
	end

	assign ack_rec   = (state == DONE) && (held_pid == PID_ACK);
	assign nak_rec   = (state == DONE) && (held_pid == PID_NAK);
	assign data0_rec = (state == DONE) && (held_pid == PID_DATA0);

endmodule : packet_fsm

// ==== source/usb_rx.sv ====
`timescale 1ns/1ps

module usb_rx import usb_line_pkg::*, usb_packet_pkg::*; #(
	parameter int PAYLOAD_BITS = 32
) (
	input  logic                    clock,
	input  logic                    reset_n,
	input  logic                    dp,
	input  logic                    dm,
	input  logic                    host_sending,
	output logic                    ack_rec,
	output logic                    nak_rec,
	output logic                    data0_rec,
	output logic                    pid_error,
	output logic                    line_error,
	output logic [PAYLOAD_BITS-1:0] payload,
	output logic                    crc_ok
);

	line_state_t line_state;
	logic        bit_val, bit_valid;
	logic        sync_seen, clear_pattern;
	pid_t        pid;
	logic        collect_start, field_done;

	line_decoder decoder_i (
		.clock, .reset_n, .dp, .dm,
		.line_state, .bit_val, .bit_valid
	);

	pattern_matcher matcher_i (
		.clock, .reset_n, .bit_val, .bit_valid, .clear_pattern,
		.sync_seen, .pid
	);

	payload_collector #(
		.PAYLOAD_BITS(PAYLOAD_BITS)
	) collector_i (
		.clock, .reset_n, .collect_start, .bit_val, .bit_valid,
		.field_done, .payload, .crc_ok
	);

	packet_fsm fsm_i (
		.clock, .reset_n, .host_sending, .line_state, .bit_valid,
		.sync_seen, .pid, .field_done,
		.clear_pattern, .collect_start,
		.ack_rec, .nak_rec, .data0_rec, .pid_error, .line_error
	);

endmodule : usb_rx

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 16
) (
	output logic clock,
	output logic reset_n
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

	// Release away from the rising edge
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset_n = 1'b1;
	end

endmodule : clock_gen

// ==== tests/usb_rx_props.sv ====
`timescale 1ns/1ps

module usb_rx_props import usb_packet_pkg::*; #(
	parameter int PAYLOAD_BITS = 32
) (
	input logic      clock,
	input logic      reset_n,
	input rx_state_t state,
	input logic      collect_start,
	input logic      field_done,
	input logic      ack_rec,
	input logic      nak_rec,
	input logic      data0_rec,
	input logic      pid_error,
	input logic      line_error
);

	localparam int FIELD_LIMIT = PAYLOAD_BITS + 20;

	logic pending;
	int   wait_cycles;

	// Cycles since the last collect_start without a field_done
	always_ff @(posedge clock, negedge reset_n) begin
		if (!reset_n) begin
			pending     <= 1'b0;
			wait_cycles <= 0;
		end else if (collect_start) begin
			pending     <= 1'b1;
			wait_cycles <= 1;
		end else if (field_done) begin
			pending <= 1'b0;
		end else if (pending) begin
			wait_cycles <= wait_cycles + 1;
		end
	end

	strobes_onehot: assert property (@(posedge clock) disable iff (!reset_n)
		$onehot0({ack_rec, nak_rec, data0_rec, pid_error, line_error}))
		else $error("More than one result strobe in one cycle");

	// A packet result only follows a complete end of packet
	result_in_done: assert property (@(posedge clock) disable iff (!reset_n)
		(ack_rec || nak_rec || data0_rec) |->
			(state == DONE) && ($past(state) == EOP_SE0B || $past(state) == EOP_J))
		else $error("Packet result strobe outside DONE or without an end of packet");

	field_in_time: assert property (@(posedge clock) disable iff (!reset_n)
		(pending && wait_cycles >= FIELD_LIMIT) |-> field_done)
		else $error("No field_done within %0d cycles of collect_start", FIELD_LIMIT);

endmodule : usb_rx_props

bind packet_fsm usb_rx_props props_i (
	.clock(clock), .reset_n(reset_n), .state(state),
	.collect_start(collect_start), .field_done(field_done),
	.ack_rec(ack_rec), .nak_rec(nak_rec), .data0_rec(data0_rec),
	.pid_error(pid_error), .line_error(line_error)
);

// ==== tests/usb_rx_tb.sv ====
`timescale 1ns/1ps

module usb_rx_tb import usb_line_pkg::*, usb_packet_pkg::*; ();

	localparam int PAYLOAD_BITS   = 32;
	localparam int NUM_ENTRIES    = 11;
	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (PAYLOAD_BITS + 60) + 100;
	localparam int STROBE_WAIT    = 10;
	localparam int SETTLE_CYCLES  = 4;
	localparam int DRIVE_DELAY_NS = 2;
	localparam pattern_t BAD_PID_CODE = 8'h3C;

	typedef enum logic [2:0] {
		KIND_ACK, KIND_NAK, KIND_DATA0, KIND_BAD_PID, KIND_EARLY_SE0, KIND_HOST_BUSY
	} kind_t;

	typedef logic [PAYLOAD_BITS-1:0] data_t;

	typedef struct packed {
		kind_t      kind;
		data_t      payload;
		logic       corrupt;
		pid_t       exp_pid;
		logic [1:0] exp_err;
		logic       exp_crc_ok;
	} entry_t;

	logic  clock, reset_n, dp, dm, host_sending;
	logic  ack_rec, nak_rec, data0_rec, pid_error, line_error, crc_ok;
	data_t payload;

	entry_t     stim_table [NUM_ENTRIES];
	int         entry_count = 0;
	integer     seed = 32'h1e01;
	int         cycle_count = 0;
	int         strobe_count = 0;
	pid_t       seen_pid;
	logic [1:0] seen_err;
	data_t      seen_payload;
	logic       seen_crc_ok;

	clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) clock_gen_i (.clock, .reset_n);

	usb_rx #(.PAYLOAD_BITS(PAYLOAD_BITS)) dut_i (
		.clock, .reset_n, .dp, .dm, .host_sending,
		.ack_rec, .nak_rec, .data0_rec, .pid_error, .line_error,
		.payload, .crc_ok
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clock) begin
		if (ack_rec || nak_rec || data0_rec || pid_error || line_error) begin
			strobe_count <= strobe_count + 1;
			seen_pid     <= {data0_rec, nak_rec, ack_rec};
			seen_err     <= {pid_error, line_error};
			seen_payload <= payload;
			seen_crc_ok  <= crc_ok;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("Timeout, the tests did not end within %0d cycles",
				TIMEOUT_CYCLES));
		end
	end

	task automatic check_pid(input int idx, input pid_t expected, input pid_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("Fail entry %0d {data0_rec,nak_rec,ack_rec}: expected %h, got %h",
				idx, expected, actual));
		end
	endtask

	task automatic check_errors(input int idx, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("Fail entry %0d {pid_error,line_error}: expected %h, got %h",
				idx, expected, actual));
		end
	endtask

	task automatic check_payload(input int idx, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("Fail entry %0d payload: expected %h, got %h",
				idx, expected, actual));
		end
	endtask

	task automatic check_crc(input int idx, input bit expected, input bit actual);
		if (actual !== expected) begin
			abort_run($sformatf("Fail entry %0d crc_ok: expected %h, got %h",
				idx, expected, actual));
		end
	endtask

	// Serial CRC16 over the payload, oldest bit first, sent inverted
	function automatic crc_t sent_crc(input data_t data);
		crc_t crc;
		logic fb;
		crc = CRC_INIT;
		for (int i = PAYLOAD_BITS - 1; i >= 0; i--) begin
			fb  = crc[15] ^ data[i];
			crc = {crc[14:0], 1'b0};
			if (fb) begin
				crc = crc ^ CRC_POLY;
			end
		end
		return ~crc;
	endfunction

	function automatic data_t random_payload();
		data_t value;
		int    word;
		for (int i = 0; i < PAYLOAD_BITS; i++) begin
			if (i % 32 == 0) begin
				word = $random(seed);
			end
			value[i] = word[i % 32];
		end
		return value;
	endfunction

	task automatic add_entry(input kind_t kind, input logic corrupt, input pid_t exp_pid,
		input logic [1:0] exp_err, input logic exp_crc_ok);
		entry_t e;
		e.kind       = kind;
		e.payload    = random_payload();
		e.corrupt    = corrupt;
		e.exp_pid    = exp_pid;
		e.exp_err    = exp_err;
		e.exp_crc_ok = exp_crc_ok;
		stim_table[entry_count] = e;
		entry_count++;
	endtask

	task automatic drive_line(input line_pair_t pair);
		@(posedge clock);
		#(DRIVE_DELAY_NS);
		{dp, dm} = pair;
	endtask

	task automatic drive_host(input logic value);
		@(posedge clock);
		#(DRIVE_DELAY_NS);
		host_sending = value;
	endtask

	task automatic send_bit(input logic b);
		drive_line(b ? PAIR_J : PAIR_K);
	endtask

	// Register shifts right, so bit 0 of a pattern goes out first
	task automatic send_byte(input pattern_t value);
		for (int i = 0; i < 8; i++) begin
			send_bit(value[i]);
		end
	endtask

	task automatic send_packet(input entry_t e);
		crc_t     crc_field;
		pattern_t pid_code;
		crc_field = sent_crc(e.payload);
		if (e.corrupt) begin
			crc_field[5] = ~crc_field[5];
		end
		case (e.kind)
			KIND_ACK, KIND_HOST_BUSY: pid_code = ACK_CODE;
			KIND_NAK:                 pid_code = NAK_CODE;
			KIND_DATA0, KIND_EARLY_SE0: pid_code = DATA0_CODE;
			default:                  pid_code = BAD_PID_CODE;
		endcase
		if (e.kind == KIND_HOST_BUSY) begin
			drive_host(1'b1);
		end
		repeat (8) drive_line(PAIR_J);
		send_byte(SYNC_PATTERN);
		send_byte(pid_code);
		if (e.kind == KIND_DATA0) begin
			for (int i = PAYLOAD_BITS - 1; i >= 0; i--) begin
				send_bit(e.payload[i]);
			end
			for (int i = 15; i >= 0; i--) begin
				send_bit(crc_field[i]);
			end
		end else if (e.kind == KIND_EARLY_SE0) begin
			// Cut off half way through the payload
			for (int i = PAYLOAD_BITS - 1; i >= PAYLOAD_BITS / 2; i--) begin
				send_bit(e.payload[i]);
			end
		end
		drive_line(PAIR_SE0);
		drive_line(PAIR_SE0);
		drive_line(PAIR_J);
		if (e.kind == KIND_HOST_BUSY) begin
			repeat (2) drive_line(PAIR_J);
			drive_host(1'b0);
		end
	endtask

	task automatic wait_for_strobe(input int start_count, output bit seen);
		seen = 1'b0;
		for (int n = 0; n < STROBE_WAIT && !seen; n++) begin
			@(posedge clock);
			if (strobe_count != start_count) begin
				seen = 1'b1;
			end
		end
	endtask

	task automatic run_entry(input int idx);
		entry_t e;
		int     start_count;
		bit     seen;
		e = stim_table[idx];
		start_count = strobe_count;
		send_packet(e);
		wait_for_strobe(start_count, seen);
		if (e.exp_pid == PID_NONE && e.exp_err == 2'b00) begin
			if (seen) begin
				abort_run($sformatf("Entry %0d gave a result strobe while the host held the bus",
					idx));
			end
		end else begin
			if (!seen) begin
				abort_run($sformatf("Entry %0d gave no result strobe within %0d cycles",
					idx, STROBE_WAIT));
			end
			repeat (SETTLE_CYCLES) @(posedge clock);
			if (strobe_count != start_count + 1) begin
				abort_run($sformatf("Entry %0d gave %0d result strobes instead of one",
					idx, strobe_count - start_count));
			end
			check_pid(idx, e.exp_pid, seen_pid);
			check_errors(idx, e.exp_err, seen_err);
			if (e.exp_pid == PID_DATA0) begin
				check_payload(idx, e.payload, seen_payload);
				check_crc(idx, e.exp_crc_ok, seen_crc_ok);
			end
		end
	endtask

	initial begin
		dp           = 1'b1;
		dm           = 1'b0;
		host_sending = 1'b0;
		// Kind, corrupt CRC, expected strobes, expected errors, expected crc_ok
		add_entry(KIND_ACK,       1'b0, PID_ACK,   2'b00, 1'b0);
		add_entry(KIND_NAK,       1'b0, PID_NAK,   2'b00, 1'b0);
		add_entry(KIND_DATA0,     1'b0, PID_DATA0, 2'b00, 1'b1);
		add_entry(KIND_DATA0,     1'b1, PID_DATA0, 2'b00, 1'b0);
		add_entry(KIND_BAD_PID,   1'b0, PID_NONE,  2'b10, 1'b0);
		add_entry(KIND_ACK,       1'b0, PID_ACK,   2'b00, 1'b0);
		add_entry(KIND_EARLY_SE0, 1'b0, PID_NONE,  2'b01, 1'b0);
		add_entry(KIND_DATA0,     1'b0, PID_DATA0, 2'b00, 1'b1);
		add_entry(KIND_HOST_BUSY, 1'b0, PID_NONE,  2'b00, 1'b0);
		add_entry(KIND_NAK,       1'b0, PID_NAK,   2'b00, 1'b0);
		add_entry(KIND_DATA0,     1'b0, PID_DATA0, 2'b00, 1'b1);
		wait (reset_n === 1'b1);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			run_entry(i);
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule : usb_rx_tb

// ==== usb_rx.f ====
source/usb_line_pkg.sv
source/usb_packet_pkg.sv
source/line_decoder.sv
source/pattern_matcher.sv
source/payload_collector.sv
source/packet_fsm.sv
source/usb_rx.sv
tests/clock_gen.sv
tests/usb_rx_props.sv
tests/usb_rx_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = usb_rx_tb
FILELIST  = usb_rx.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
